//--- adc_cap_pkg.sv
`default_nettype none

package adc_cap_pkg;

  // --------------------------------------------------
  // sample format
  // --------------------------------------------------

  // converter resolution, one sample per conversion
  localparam int RESOLUTION = 18;

  // gate length in core cycles
  // one lane takes a bit per cycle, two lanes take a pair
  localparam int BITS_ONE_LANE = 18;
  localparam int BITS_TWO_LANE = 9;

  // --------------------------------------------------
  // conversion timing
  // --------------------------------------------------

  // strobe to gate open, covers the converter busy time
  localparam int CONV_CYCLES = 3;

  // shortest frame, strobe + wait + longest gate + a little slack
  localparam logic [15:0] MIN_PERIOD = 16'(CONV_CYCLES + BITS_ONE_LANE + 3);

  // substituted for the lane data in test mode
  localparam logic [RESOLUTION-1:0] TEST_PATTERN = 18'h3a5a5;

  // --------------------------------------------------
  // register map
  // --------------------------------------------------

  // byte addresses on the 4-bit wishbone address
  localparam logic [3:0] ADDR_CTRL   = 4'h0;
  localparam logic [3:0] ADDR_PERIOD = 4'h4;
  localparam logic [3:0] ADDR_SAMPLE = 4'h8;
  localparam logic [3:0] ADDR_COUNT  = 4'hc;

  // control register fields
  localparam int CTRL_EN       = 0;
  localparam int CTRL_TWOLANES = 1;
  localparam int CTRL_TESTPAT  = 2;
  localparam int CTRL_PD       = 3;

endpackage

`default_nettype wire

//--- adc_cfg_if.sv
`timescale 1ns/1ns
`default_nettype none

interface adc_cfg_if import adc_cap_pkg::*; ();

  // control bits, written over wishbone
  logic                  enable;
  logic                  twolanes;
  logic                  testpat;
  logic                  pd;

  // conversion period in core cycles, already clamped
  logic [15:0]           period;

  // assembled sample and its one-cycle strobe
  logic [RESOLUTION-1:0] sample;
  logic                  sample_strobe;

  // register block drives config, sees the sample stream
  modport regs (
    output enable, twolanes, testpat, pd, period,
    input  sample, sample_strobe
  );

  // timer only needs the run controls and the lane mode
  modport timer (
    input enable, pd, twolanes, period
  );

  // deserializer makes the samples
  modport deser (
    input  twolanes, testpat,
    output sample, sample_strobe
  );

endinterface

`default_nettype wire

//--- adc_regs.sv
`timescale 1ns/1ns
`default_nettype none

module adc_regs import adc_cap_pkg::*; (
  input  wire         clk_gate,
  input  wire         arst_n,
  input  wire         wb_cyc,
  input  wire         wb_stb,
  input  wire         wb_we,
  input  wire  [3:0]  wb_adr,
  input  wire  [31:0] wb_wdata,
  output logic [31:0] wb_rdata,
  output logic        wb_ack,
  adc_cfg_if.regs     cfg
);

  // new request, not yet acked
  logic                  req;
  logic                  wr;
  logic                  rd;

  // register storage
  logic [3:0]            ctrl_q;
  logic [15:0]           period_q;
  logic [RESOLUTION-1:0] last_sample;
  logic [31:0]           sample_cnt;

  // write value after clamping
  logic [15:0]           period_wr;

  // read data before the output register
  logic [31:0]           rd_mux;

  // --------------------------------------------------
  // bus decode
  // --------------------------------------------------

  // ack is blocked for the cycle it is high, so a held stb
  // does not start a second access
  assign req = wb_cyc & wb_stb & ~wb_ack;
  assign wr  = req & wb_we;
  assign rd  = req & ~wb_we;

  // periods below the frame length would overlap frames
  assign period_wr = (wb_wdata[15:0] < MIN_PERIOD) ? MIN_PERIOD : wb_wdata[15:0];

  always_comb begin
    case (wb_adr)
      ADDR_CTRL:   rd_mux = {28'd0, ctrl_q};
      ADDR_PERIOD: rd_mux = {16'd0, period_q};
      ADDR_SAMPLE: rd_mux = {{(32-RESOLUTION){1'b0}}, last_sample};
      ADDR_COUNT:  rd_mux = sample_cnt;
      // holes in the map read zero
      default:     rd_mux = 32'd0;
    endcase
  end

  // ack and read data come out together, one cycle after the request
  always_ff @(posedge clk_gate or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack   <= 1'b0;
      wb_rdata <= 32'd0;
    end else begin
      wb_ack   <= req;
      wb_rdata <= rd ? rd_mux : 32'd0;
    end
  end

  // --------------------------------------------------
  // control and period
  // --------------------------------------------------

  always_ff @(posedge clk_gate or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_q   <= 4'd0;
      period_q <= MIN_PERIOD;
    end else if (wr) begin
      if (wb_adr == ADDR_CTRL) begin
        ctrl_q <= wb_wdata[3:0];
      end
      if (wb_adr == ADDR_PERIOD) begin
        period_q <= period_wr;
      end
    end
  end

  // fan the control bits out to timer and deserializer
  assign cfg.enable   = ctrl_q[CTRL_EN];
  assign cfg.twolanes = ctrl_q[CTRL_TWOLANES];
  assign cfg.testpat  = ctrl_q[CTRL_TESTPAT];
  assign cfg.pd       = ctrl_q[CTRL_PD];
  assign cfg.period   = period_q;

  // --------------------------------------------------
  // sample status
  // --------------------------------------------------

  // last sample, only replaced on a strobe
  always_ff @(posedge clk_gate) begin
    if (cfg.sample_strobe) begin
      last_sample <= cfg.sample;
    end
  end

  // wrapping sample counter
  // a write to the count address clears it, even on a strobe
  always_ff @(posedge clk_gate or negedge arst_n) begin
    if (!arst_n) begin
      sample_cnt <= 32'd0;
    end else if (wr && (wb_adr == ADDR_COUNT)) begin
      sample_cnt <= 32'd0;
    end else if (cfg.sample_strobe) begin
      sample_cnt <= sample_cnt + 32'd1;
    end
  end

endmodule

`default_nettype wire

//--- adc_conv_timer.sv
`timescale 1ns/1ns
`default_nettype none

module adc_conv_timer import adc_cap_pkg::*; (
  input  wire      clk_gate,
  input  wire      arst_n,
  adc_cfg_if.timer cfg,
  output logic     cnv,
  output logic     gate,
  output logic     pd
);

  // new strobes allowed
  logic        run;
  // issue a strobe on this edge
  logic        fire;
  logic [15:0] period_cnt;

  // frame in flight, phase counts cycles since cnv
  logic        busy;
  logic [4:0]  phase;
  // gate length latched at the strobe
  logic [4:0]  lane_bits;
  // phase of the last edge that keeps the gate open
  logic [4:0]  gate_last;

  // --------------------------------------------------
  // period counter
  // --------------------------------------------------

  assign run = cfg.enable & ~cfg.pd;

  // >= so a shorter period written mid-count takes effect at once
  assign fire = run && (period_cnt >= (cfg.period - 16'd1));

  always_ff @(posedge clk_gate or negedge arst_n) begin
    if (!arst_n) begin
      period_cnt <= 16'd0;
      cnv        <= 1'b0;
    end else begin
      cnv <= fire;
      // idle holds the count at zero, first strobe one period after enable
      if (!run || fire) begin
        period_cnt <= 16'd0;
      end else begin
        period_cnt <= period_cnt + 16'd1;
      end
    end
  end

  // --------------------------------------------------
  // conversion wait and gate window
  // --------------------------------------------------

  // phase k is held in cycle t+k, gate is registered one phase early
  assign gate_last = 5'(CONV_CYCLES - 1) + lane_bits;

  always_ff @(posedge clk_gate or negedge arst_n) begin
    if (!arst_n) begin
      busy      <= 1'b0;
      phase     <= 5'd0;
      lane_bits <= 5'(BITS_ONE_LANE);
      gate      <= 1'b0;
    end else begin
      gate <= busy && (phase >= 5'(CONV_CYCLES)) && (phase <= gate_last);
      if (fire) begin
        // mode is frozen here, later writes wait for the next frame
        busy      <= 1'b1;
        phase     <= 5'd0;
        lane_bits <= cfg.twolanes ? 5'(BITS_TWO_LANE) : 5'(BITS_ONE_LANE);
      end else if (busy) begin
        phase <= phase + 5'd1;
        // frame keeps running after enable drops
        if (phase == gate_last) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // power-down pin follows the control bit a cycle late
  always_ff @(posedge clk_gate or negedge arst_n) begin
    if (!arst_n) begin
      pd <= 1'b0;
    end else begin
      pd <= cfg.pd;
    end
  end

endmodule

`default_nettype wire

//--- adc_lane_deser.sv
`timescale 1ns/1ns
`default_nettype none

module adc_lane_deser import adc_cap_pkg::*; (
  input  wire      clk_gate,
  input  wire      arst_n,
  input  wire      gate,
  input  wire      da,
  input  wire      db,
  adc_cfg_if.deser cfg
);

  // gate delayed one cycle, the lanes lag the gate by one cycle
  logic                  sample_en;
  logic                  win_start;
  logic                  win_end;

  // modes frozen for the current window
  logic                  mode_two;
  logic                  mode_test;

  logic [RESOLUTION-1:0] shreg;
  logic [RESOLUTION-1:0] shreg_nxt;

  // --------------------------------------------------
  // window tracking
  // --------------------------------------------------

  // first gate cycle, enable not yet up
  assign win_start = gate & ~sample_en;
  // last bit on the lanes, gate already low
  assign win_end   = sample_en & ~gate;

  always_ff @(posedge clk_gate or negedge arst_n) begin
    if (!arst_n) begin
      sample_en <= 1'b0;
      mode_two  <= 1'b0;
      mode_test <= 1'b0;
    end else begin
      sample_en <= gate;
      if (win_start) begin
        mode_two  <= cfg.twolanes;
        mode_test <= cfg.testpat;
      end
    end
  end

  // --------------------------------------------------
  // shift register
  // --------------------------------------------------

  // msb first
  // two lanes give an even/odd pair per cycle, lane a is the higher bit
  always_comb begin
    if (mode_two) begin
      shreg_nxt = {shreg[RESOLUTION-3:0], da, db};
    end else begin
      shreg_nxt = {shreg[RESOLUTION-2:0], da};
    end
  end

  // a full window overwrites every bit, no clear needed
  always_ff @(posedge clk_gate) begin
    if (sample_en) begin
      shreg <= shreg_nxt;
    end
  end

  // --------------------------------------------------
  // sample output
  // --------------------------------------------------

  // word is loaded on the edge that takes the last bit
  always_ff @(posedge clk_gate) begin
    if (win_end) begin
      cfg.sample <= mode_test ? TEST_PATTERN : shreg_nxt;
    end
  end

  // single-cycle strobe, nothing downstream can stall it
  always_ff @(posedge clk_gate or negedge arst_n) begin
    if (!arst_n) begin
      cfg.sample_strobe <= 1'b0;
    end else begin
      cfg.sample_strobe <= win_end;
    end
  end

endmodule

`default_nettype wire

//--- adc_capture_top.sv
`timescale 1ns/1ns
`default_nettype none

module adc_capture_top import adc_cap_pkg::*; (
  input  wire                   clk_gate,
  input  wire                   arst_n,
  // wishbone classic slave
  input  wire                   wb_cyc,
  input  wire                   wb_stb,
  input  wire                   wb_we,
  input  wire  [3:0]            wb_adr,
  input  wire  [31:0]           wb_wdata,
  output wire  [31:0]           wb_rdata,
  output wire                   wb_ack,
  // converter pins
  input  wire                   da,
  input  wire                   db,
  output wire                   cnv,
  output wire                   gate,
  output wire                   pd,
  // sample stream
  output wire                   adc_valid,
  output wire  [RESOLUTION-1:0] adc_data
);

  // config and status between the blocks
  adc_cfg_if cfg ();

  adc_regs u_regs (
    .clk_gate (clk_gate),
    .arst_n   (arst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_wdata (wb_wdata),
    .wb_rdata (wb_rdata),
    .wb_ack   (wb_ack),
    .cfg      (cfg.regs)
  );

  // gate goes out to the pin and into the deserializer
  adc_conv_timer u_timer (
    .clk_gate (clk_gate),
    .arst_n   (arst_n),
    .cfg      (cfg.timer),
    .cnv      (cnv),
    .gate     (gate),
    .pd       (pd)
  );

  adc_lane_deser u_deser (
    .clk_gate (clk_gate),
    .arst_n   (arst_n),
    .gate     (gate),
    .da       (da),
    .db       (db),
    .cfg      (cfg.deser)
  );

  // the sample stream is the deserializer output as is
  assign adc_valid = cfg.sample_strobe;
  assign adc_data  = cfg.sample;

endmodule

`default_nettype wire

//--- adc_capture_sva.sv
`timescale 1ns/1ns
`default_nettype none

module adc_capture_sva import adc_cap_pkg::*; (
  input wire clk_gate,
  input wire arst_n,
  input wire wb_cyc,
  input wire wb_stb,
  input wire wb_ack,
  input wire cnv,
  input wire gate,
  input wire pd,
  input wire adc_valid,
  input wire twolanes
);

  int fail_cnt = 0;

  // mode the timer froze for the current frame
  logic       two_d;
  logic       two_frame;
  // gate-high cycles so far
  logic [4:0] gate_len;

  always_ff @(posedge clk_gate or negedge arst_n) begin
    if (!arst_n) begin
      two_d     <= 1'b0;
      two_frame <= 1'b0;
      gate_len  <= 5'd0;
    end else begin
      two_d    <= twolanes;
      if (cnv) begin
        two_frame <= two_d;
      end
      gate_len <= gate ? gate_len + 5'd1 : 5'd0;
    end
  end

  // --------------------------------------------------
  // properties
  // --------------------------------------------------

  a_cnv_width: assert property (@(posedge clk_gate) disable iff (!arst_n) cnv |=> !cnv)
    else begin
      $error("cnv wider than one cycle");
      fail_cnt++;
    end

  // gate opens once the conversion wait has run out
  a_gate_open: assert property (@(posedge clk_gate) disable iff (!arst_n)
    cnv |-> ##(CONV_CYCLES + 1) $rose(gate))
    else begin
      $error("gate did not open after the conversion wait");
      fail_cnt++;
    end

  a_gate_len: assert property (@(posedge clk_gate) disable iff (!arst_n)
    $fell(gate) |-> gate_len == (two_frame ? 5'(BITS_TWO_LANE) : 5'(BITS_ONE_LANE)))
    else begin
      $error("gate length does not match lane mode");
      fail_cnt++;
    end

  // valid two cycles after the last gate-high cycle
  a_valid_pos: assert property (@(posedge clk_gate) disable iff (!arst_n)
    adc_valid |-> $past(gate, 2) && !$past(gate))
    else begin
      $error("adc_valid misplaced against gate");
      fail_cnt++;
    end

  a_ack_req: assert property (@(posedge clk_gate) disable iff (!arst_n)
    wb_ack |-> $past(wb_cyc && wb_stb))
    else begin
      $error("wb_ack without a request");
      fail_cnt++;
    end

  a_pd_cnv: assert property (@(posedge clk_gate) disable iff (!arst_n) !(cnv && pd))
    else begin
      $error("cnv while powered down");
      fail_cnt++;
    end

endmodule

bind adc_capture_top adc_capture_sva u_sva (
  .clk_gate  (clk_gate),
  .arst_n    (arst_n),
  .wb_cyc    (wb_cyc),
  .wb_stb    (wb_stb),
  .wb_ack    (wb_ack),
  .cnv       (cnv),
  .gate      (gate),
  .pd        (pd),
  .adc_valid (adc_valid),
  .twolanes  (cfg.twolanes)
);

`default_nettype wire

//--- tb_adc_capture.sv
`timescale 1ns/1ns
`default_nettype none

module tb_adc_capture import adc_cap_pkg::*; ();

  // run lengths and periods
  localparam int N_RUN   = 20;
  localparam int N_PAT   = 5;
  localparam int PER_RUN = 32;
  localparam int PER_CHK = 40;
  localparam int QUIET   = 3 * PER_CHK;
  // conversions over all tests at the slow period plus quiet windows and ~60 bus accesses
  localparam int N_CONV     = 2 * N_RUN + N_PAT + 10;
  localparam int MAX_CYCLES = N_CONV * PER_CHK + 2 * QUIET + 60 * 4 + 1000;

  localparam logic [31:0] EN  = 32'd1 << CTRL_EN;
  localparam logic [31:0] TWO = 32'd1 << CTRL_TWOLANES;
  localparam logic [31:0] PAT = 32'd1 << CTRL_TESTPAT;
  localparam logic [31:0] PD  = 32'd1 << CTRL_PD;

  logic clk_gate, arst_n, wb_cyc, wb_stb, wb_we, da, db;
  logic [3:0]  wb_adr;
  logic [31:0] wb_wdata, wb_rdata;
  logic wb_ack, cnv, gate, pd, adc_valid;
  logic [RESOLUTION-1:0] adc_data;

  // model and scoreboard state
  logic [31:0] lfsr_state = 32'd92119;
  logic two_mode = 1'b0, pat_mode = 1'b0, gate_seen = 1'b0;
  logic [RESOLUTION-1:0] frame, last_exp;
  logic [RESOLUTION-1:0] exp_q[$];
  int pos, cyc = 0, checks = 0, errors = 0;
  int cnv_cnt = 0, valid_cnt = 0, run_id = 0, cnv_run = -1, last_cnv = 0;
  int cur_period = PER_CHK;
  // samples the model has sent since reset
  int sent_cnt = 0;

  adc_capture_top dut (.*);

  initial begin
    clk_gate = 1'b0;
    forever #20 clk_gate = ~clk_gate;
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'd0);
  endfunction

  function automatic logic take_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_step(lfsr_state);
    return b;
  endfunction

  function automatic logic [RESOLUTION-1:0] rand_sample();
    logic [RESOLUTION-1:0] s;
    for (int i = 0; i < RESOLUTION; i++) s[i] = take_bit();
    return s;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // classic cycle with stb dropped on the edge that sees ack
  task automatic wb_write(input logic [3:0] adr, input logic [31:0] data);
    @(posedge clk_gate);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we <= 1'b1;
    wb_adr <= adr;
    wb_wdata <= data;
    @(posedge clk_gate);
    while (!wb_ack) @(posedge clk_gate);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we <= 1'b0;
  endtask

  task automatic reg_check(input string name, input logic [3:0] adr, input logic [31:0] exp);
    @(posedge clk_gate);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we <= 1'b0;
    wb_adr <= adr;
    @(posedge clk_gate);
    while (!wb_ack) @(posedge clk_gate);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    check_eq(name, wb_rdata, exp);
  endtask

  // every cnv yields one valid so equal counts mean an empty pipe
  task automatic drain();
    @(negedge clk_gate);
    while (valid_cnt != cnv_cnt) @(negedge clk_gate);
  endtask

  task automatic run_frames(input logic [31:0] mode, input int n, input int per);
    int target;
    two_mode = mode[CTRL_TWOLANES];
    pat_mode = mode[CTRL_TESTPAT];
    cur_period = (per < MIN_PERIOD) ? MIN_PERIOD : per;
    wb_write(ADDR_PERIOD, per);
    run_id++;
    target = valid_cnt + n;
    wb_write(ADDR_CTRL, mode | EN);
    while (valid_cnt < target) @(negedge clk_gate);
    wb_write(ADDR_CTRL, 32'd0);
    drain();
  endtask

  // --------------------------------------------------
  // adc model and monitor
  // --------------------------------------------------

  // lanes change on the edge after a gate-high cycle with the msb first
  always @(posedge clk_gate) begin
    if (gate) begin
      if (!gate_seen) begin
        frame = rand_sample();
        exp_q.push_back(pat_mode ? TEST_PATTERN : frame);
        sent_cnt++;
        pos = RESOLUTION - 1;
      end
      da <= frame[pos];
      if (two_mode) begin
        db <= frame[pos-1];
        pos = pos - 2;
      end else begin
        // noise on the unused lane
        db <= take_bit();
        pos = pos - 1;
      end
    end
    gate_seen = gate;
  end

  always @(posedge clk_gate) begin
    cyc++;
    if (cnv) begin
      cnv_cnt++;
      if (cnv_run == run_id) check_eq("cnv interval", cyc - last_cnv, cur_period);
      cnv_run = run_id;
      last_cnv = cyc;
    end
    if (adc_valid) begin
      valid_cnt++;
      if (exp_q.size() == 0) begin
        $display("adc_valid pulsed with no sample sent by the model");
        errors++;
      end else begin
        last_exp = exp_q.pop_front();
        check_eq("adc_data", adc_data, last_exp);
      end
    end
  end

  initial begin
    wait (cyc >= MAX_CYCLES);
    $display("timeout, run still busy after %0d cycles", cyc);
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
             dut.u_sva.fail_cnt);
    $display("Some tests failed");
    $finish;
  end

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------

  initial begin
    int base;
    int total;
    arst_n = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = 4'd0;
    wb_wdata = 32'd0;
    da = 1'b0;
    db = 1'b0;
    repeat (4) @(posedge clk_gate);
    arst_n <= 1'b1;

    // register map with reset values, clamp and holes
    reg_check("ctrl reset", ADDR_CTRL, 32'd0);
    reg_check("period reset", ADDR_PERIOD, MIN_PERIOD);
    reg_check("count reset", ADDR_COUNT, 32'd0);
    wb_write(ADDR_CTRL, TWO | PAT | PD);
    reg_check("ctrl", ADDR_CTRL, TWO | PAT | PD);
    wb_write(ADDR_CTRL, 32'hffff_fff0);
    reg_check("ctrl upper bits", ADDR_CTRL, 32'd0);
    wb_write(ADDR_PERIOD, 32'h1234_0064);
    reg_check("period", ADDR_PERIOD, 32'h64);
    wb_write(ADDR_PERIOD, 32'd5);
    reg_check("period clamp", ADDR_PERIOD, MIN_PERIOD);
    reg_check("unmapped 2", 4'h2, 32'd0);
    reg_check("unmapped 7", 4'h7, 32'd0);
    reg_check("unmapped f", 4'hf, 32'd0);

    // the short two-lane period goes through the clamp
    run_frames(32'd0, N_RUN, PER_RUN);
    run_frames(TWO, N_RUN, 10);
    run_frames(PAT, N_PAT, PER_RUN);

    // period, power-down and stop
    two_mode = 1'b0;
    pat_mode = 1'b0;
    cur_period = PER_CHK;
    wb_write(ADDR_PERIOD, PER_CHK);
    run_id++;
    wb_write(ADDR_CTRL, EN);
    base = cnv_cnt;
    while (cnv_cnt < base + 4) @(negedge clk_gate);
    wb_write(ADDR_CTRL, EN | PD);
    @(negedge clk_gate);
    check_eq("pd", pd, 1'b1);
    drain();
    base = cnv_cnt;
    repeat (QUIET) @(negedge clk_gate);
    check_eq("cnv count in power-down", cnv_cnt, base);
    run_id++;
    wb_write(ADDR_CTRL, EN);
    @(negedge clk_gate);
    check_eq("pd", pd, 1'b0);
    while (cnv_cnt < base + 2) @(negedge clk_gate);
    wb_write(ADDR_CTRL, 32'd0);
    drain();
    base = cnv_cnt;
    repeat (QUIET) @(negedge clk_gate);
    check_eq("cnv count after disable", cnv_cnt, base);

    // status registers
    reg_check("last sample", ADDR_SAMPLE, last_exp);
    reg_check("sample count", ADDR_COUNT, sent_cnt);
    wb_write(ADDR_COUNT, 32'hdead_beef);
    reg_check("count clear", ADDR_COUNT, 32'd0);
    check_eq("expected queue depth", exp_q.size(), 32'd0);

    total = errors + dut.u_sva.fail_cnt;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
             dut.u_sva.fail_cnt);
    if (total == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
adc_cap_pkg.sv
adc_cfg_if.sv
adc_regs.sv
adc_conv_timer.sv
adc_lane_deser.sv
adc_capture_top.sv
adc_capture_sva.sv
tb_adc_capture.sv

//--- Bender.yml
package:
  name: adc_capture

sources:
  - files:
      - adc_cap_pkg.sv
      - adc_cfg_if.sv
      - adc_regs.sv
      - adc_conv_timer.sv
      - adc_lane_deser.sv
      - adc_capture_top.sv
  - target: test
    files:
      - adc_capture_sva.sv
      - tb_adc_capture.sv
